// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// Opcodes in instruction bits [15:12]
	localparam logic [3:0] opAdd  = 4'd0;
	localparam logic [3:0] opAddz = 4'd1;
	localparam logic [3:0] opSub  = 4'd2;
	localparam logic [3:0] opAnd  = 4'd3;
	localparam logic [3:0] opNor  = 4'd4;
	localparam logic [3:0] opSll  = 4'd5;
	localparam logic [3:0] opSrl  = 4'd6;
	localparam logic [3:0] opSra  = 4'd7;
	localparam logic [3:0] opLw   = 4'd8;
	localparam logic [3:0] opSw   = 4'd9;
	localparam logic [3:0] opLhb  = 4'd10;
	localparam logic [3:0] opLlb  = 4'd11;
	localparam logic [3:0] opB    = 4'd12;
	localparam logic [3:0] opJal  = 4'd13;
	localparam logic [3:0] opJr   = 4'd14;
	localparam logic [3:0] opHlt  = 4'd15;

	// ALU functions that ALU opcodes carry in their low bits
	localparam logic [2:0] fnAdd = 3'd0;
	localparam logic [2:0] fnLhb = 3'd1;
	localparam logic [2:0] fnSub = 3'd2;
	localparam logic [2:0] fnAnd = 3'd3;
	localparam logic [2:0] fnNor = 3'd4;
	localparam logic [2:0] fnSll = 3'd5;
	localparam logic [2:0] fnSrl = 3'd6;
	localparam logic [2:0] fnSra = 3'd7;

	// Branch conditions in bits [11:9]
	localparam logic [2:0] condNe     = 3'd0;
	localparam logic [2:0] condEq     = 3'd1;
	localparam logic [2:0] condGt     = 3'd2;
	localparam logic [2:0] condLt     = 3'd3;
	localparam logic [2:0] condGte    = 3'd4;
	localparam logic [2:0] condLte    = 3'd5;
	localparam logic [2:0] condOvfl   = 3'd6;
	localparam logic [2:0] condUncond = 3'd7;

	// One instruction word seen through three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt;
		} rFmt;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [7:0] imm8;
		} iFmt;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] cond;
			logic [8:0] offset9;
		} bFmt;
	} instrWord_t;

endpackage

`default_nettype wire

// ==== source/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode
	import cpuPkg::*;
(
	input  instrWord_t  instr,
	input  logic [15:0] pcPlus1,
	input  logic        zr,
	input  logic        ne,
	input  logic        ov,
	output logic [15:0] nextAddr,
	output logic [3:0]  p0Addr,
	output logic [3:0]  p1Addr,
	output logic [3:0]  dstAddr,
	output logic [3:0]  shamt,
	output logic        re0,
	output logic        re1,
	output logic        memRe,
	output logic        we,
	output logic        memWe,
	output logic        memOp,
	output logic        aluOp,
	output logic        jal,
	output logic        jr,
	output logic        hlt,
	output logic        src0Sel,
	output logic [2:0]  func,
	output logic        memToReg
);

	logic [3:0]  opcode;
	logic        isB;
	logic        isLhb;
	logic        isLlb;
	logic        taken;
	logic [15:0] branchOff;
	logic [15:0] jalOff;

	// Decode views of the same word
	assign opcode = instr.rFmt.opcode;

	// Class strobes
	assign aluOp = !opcode[3];
	assign isB   = (opcode == opB);
	assign isLhb = (opcode == opLhb);
	assign isLlb = (opcode == opLlb);
	assign jal   = (opcode == opJal);
	assign jr    = (opcode == opJr);
	assign hlt   = (opcode == opHlt);

	// Memory strobes
	assign memWe    = (opcode == opSw);
	assign memToReg = (opcode == opLw);
	assign memRe    = memToReg;
	assign memOp    = memWe | memToReg;

	// Reads stay on until halt
	assign re0 = !hlt;
	assign re1 = !hlt;

	// Branch condition from the flag register
	always_comb begin
		case (instr.bFmt.cond)
			condNe:   taken = !zr;
			condEq:   taken = zr;
			condGt:   taken = !(zr || ne);
			condLt:   taken = ne;
			condGte:  taken = !ne;
			condLte:  taken = ne || zr;
			condOvfl: taken = ov;
			default:  taken = 1'b1;
		endcase
	end

	// Sign extended offsets
	assign branchOff = {{7{instr.bFmt.offset9[8]}}, instr.bFmt.offset9};
	assign jalOff    = {{4{instr.iFmt.rd[3]}}, instr.iFmt.rd, instr.iFmt.imm8};

	// Not taken falls through to pcPlus1
	assign nextAddr = (isB && taken) ? pcPlus1 + branchOff :
		jal ? pcPlus1 + jalOff :
		pcPlus1;

	// LHB keeps the low byte of rd
	assign p0Addr = isLhb ? instr.rFmt.rd : instr.rFmt.rs;

	// SW data and LHB source sit in rd and LLB reads R0 on this port
	always_comb begin
		if (memWe || isLhb)
			p1Addr = instr.rFmt.rd;
		else if (memToReg)
			p1Addr = instr.rFmt.rs;
		else if (isLlb)
			p1Addr = 4'h0;
		else
			p1Addr = instr.rFmt.rt;
	end

	// ADDZ without zr writes into R0 and is lost
	always_comb begin
		if (jal)
			dstAddr = 4'hf;
		else if (isB)
			dstAddr = 4'h0;
		else if (opcode == opAddz && !zr)
			dstAddr = 4'h0;
		else
			dstAddr = instr.rFmt.rd;
	end

	// Shift amount and load/store offset share the rt field
	assign shamt = instr.rFmt.rt;

	assign we      = aluOp | jal | memToReg | isLhb | isLlb;
	assign src0Sel = isLhb | isLlb;

	// ADDZ shares the adder and loads and stores add their offset
	always_comb begin
		if (aluOp)
			func = (opcode == opAddz) ? fnAdd : opcode[2:0];
		else if (isLhb)
			func = fnLhb;
		else
			func = fnAdd;
	end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [3:0]  p0Addr,
	input  logic [3:0]  p1Addr,
	input  logic [3:0]  dstAddr,
	input  logic [3:0]  dbgAddr,
	input  logic        we,
	input  logic [15:0] writeData,
	output logic [15:0] p0Data,
	output logic [15:0] p1Data,
	output logic [15:0] dbgData
);

	logic [15:0] regs [16];

	// R0 never takes a write
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we && dstAddr != 4'h0) begin
			regs[dstAddr] <= writeData;
		end
	end

	// Asynchronous reads with R0 forced to zero
	assign p0Data  = (p0Addr == 4'h0) ? '0 : regs[p0Addr];
	assign p1Data  = (p1Addr == 4'h0) ? '0 : regs[p1Addr];
	assign dbgData = (dbgAddr == 4'h0) ? '0 : regs[dbgAddr];

	// Write address settled whenever a write happens
	assert property (@(posedge clk) disable iff (!arstN) we |-> !$isunknown(dstAddr));

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  logic [15:0] p0Data,
	input  logic [15:0] p1Data,
	input  logic [7:0]  imm8,
	input  logic [3:0]  shamt,
	input  logic [2:0]  func,
	input  logic        aluOp,
	input  logic        src0Sel,
	output logic [15:0] result,
	output logic        zr,
	output logic        ne,
	output logic        ov
);

	logic [15:0] opB;
	logic [15:0] sum;
	logic [15:0] diff;
	logic        addOv;
	logic        subOv;

	// Immediate for LLB/LHB, offset for memory ops, register otherwise
	always_comb begin
		if (src0Sel)
			opB = {{8{imm8[7]}}, imm8};
		else if (aluOp)
			opB = p1Data;
		else
			opB = {{12{shamt[3]}}, shamt};
	end

	assign sum  = p0Data + opB;
	assign diff = p0Data - opB;

	// Signed overflow flips the result sign away from the first operand
	assign addOv = (p0Data[15] == opB[15]) && (sum[15] != p0Data[15]);
	assign subOv = (p0Data[15] != opB[15]) && (diff[15] != p0Data[15]);

	always_comb begin
		case (func)
			fnAdd:   result = sum;
			fnLhb:   result = {imm8, p0Data[7:0]};
			fnSub:   result = diff;
			fnAnd:   result = p0Data & opB;
			fnNor:   result = ~(p0Data | opB);
			fnSll:   result = p0Data << shamt;
			fnSrl:   result = p0Data >> shamt;
			default: result = $signed(p0Data) >>> shamt;
		endcase
	end

	// Flags only follow arithmetic ALU instructions
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			zr <= 1'b0;
			ne <= 1'b0;
			ov <= 1'b0;
		end else if (aluOp && (func == fnAdd || func == fnSub)) begin
			zr <= (result == 16'h0);
			ne <= result[15];
			ov <= (func == fnSub) ? subOv : addOv;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN) !$isunknown({zr, ne, ov}));

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
	import cpuPkg::*;
#(
	parameter int imemAddrBits = 8
) (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic [15:0]             nextAddr,
	input  logic [15:0]             jrTarget,
	input  logic                    jr,
	input  logic                    hlt,
	input  logic                    imemWe,
	input  logic [imemAddrBits-1:0] imemAddr,
	input  logic [15:0]             imemData,
	output instrWord_t              instr,
	output logic [15:0]             pcPlus1,
	output logic [15:0]             pc,
	output logic                    halted
);

	logic [15:0] imem [2**imemAddrBits];

	// Program load only under reset
	always_ff @(posedge clk) begin
		if (imemWe && !arstN)
			imem[imemAddr] <= imemData;
	end

	assign instr   = imem[pc[imemAddrBits-1:0]];
	assign pcPlus1 = pc + 16'd1;

	// PC parks on HLT so the core stays frozen
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else if (!hlt && !halted)
			pc <= jr ? jrTarget : nextAddr;
	end

	// Halt latch cleared only by reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			halted <= 1'b0;
		else if (hlt)
			halted <= 1'b1;
	end

	assert property (@(posedge clk) arstN |-> !imemWe);

endmodule

`default_nettype wire

// ==== source/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
	parameter int dmemAddrBits = 8
) (
	input  logic                    clk,
	input  logic [dmemAddrBits-1:0] addr,
	input  logic [15:0]             writeData,
	input  logic                    memWe,
	input  logic                    memRe,
	output logic [15:0]             readData
);

	logic [15:0] mem [2**dmemAddrBits];

	// Store on the edge
	always_ff @(posedge clk) begin
		if (memWe)
			mem[addr] <= writeData;
	end

	// Combinational read that gives zero when idle
	assign readData = memRe ? mem[addr] : '0;

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore
	import cpuPkg::*;
#(
	parameter int imemAddrBits = 8,
	parameter int dmemAddrBits = 8
) (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    imemWe,
	input  logic [imemAddrBits-1:0] imemAddr,
	input  logic [15:0]             imemData,
	input  logic [3:0]              dbgAddr,
	output logic [15:0]             pc,
	output logic                    halted,
	output logic [15:0]             dbgData
);

	instrWord_t  instr;
	logic [15:0] pcPlus1;
	logic [15:0] nextAddr;
	logic [3:0]  p0Addr;
	logic [3:0]  p1Addr;
	logic [3:0]  dstAddr;
	logic [3:0]  shamt;
	logic        memRe;
	logic        we;
	logic        memWe;
	logic        aluOp;
	logic        jal;
	logic        jr;
	logic        hlt;
	logic        src0Sel;
	logic [2:0]  func;
	logic        memToReg;
	logic [15:0] p0Data;
	logic [15:0] p1Data;
	logic [15:0] aluResult;
	logic [15:0] memData;
	logic [15:0] writeData;
	logic        zr;
	logic        ne;
	logic        ov;

	fetchUnit #(
		.imemAddrBits(imemAddrBits)
	) fetchUnit_inst (
		.clk      (clk),
		.arstN    (arstN),
		.nextAddr (nextAddr),
		.jrTarget (p0Data),
		.jr       (jr),
		.hlt      (hlt),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.instr    (instr),
		.pcPlus1  (pcPlus1),
		.pc       (pc),
		.halted   (halted)
	);

	// Read enables and memOp are not needed by the single-cycle datapath
	instrDecode instrDecode_inst (
		.instr    (instr),
		.pcPlus1  (pcPlus1),
		.zr       (zr),
		.ne       (ne),
		.ov       (ov),
		.nextAddr (nextAddr),
		.p0Addr   (p0Addr),
		.p1Addr   (p1Addr),
		.dstAddr  (dstAddr),
		.shamt    (shamt),
		.re0      (),
		.re1      (),
		.memRe    (memRe),
		.we       (we),
		.memWe    (memWe),
		.memOp    (),
		.aluOp    (aluOp),
		.jal      (jal),
		.jr       (jr),
		.hlt      (hlt),
		.src0Sel  (src0Sel),
		.func     (func),
		.memToReg (memToReg)
	);

	regFile regFile_inst (
		.clk       (clk),
		.arstN     (arstN),
		.p0Addr    (p0Addr),
		.p1Addr    (p1Addr),
		.dstAddr   (dstAddr),
		.dbgAddr   (dbgAddr),
		.we        (we),
		.writeData (writeData),
		.p0Data    (p0Data),
		.p1Data    (p1Data),
		.dbgData   (dbgData)
	);

	alu alu_inst (
		.clk     (clk),
		.arstN   (arstN),
		.p0Data  (p0Data),
		.p1Data  (p1Data),
		.imm8    (instr.iFmt.imm8),
		.shamt   (shamt),
		.func    (func),
		.aluOp   (aluOp),
		.src0Sel (src0Sel),
		.result  (aluResult),
		.zr      (zr),
		.ne      (ne),
		.ov      (ov)
	);

	// Address is base plus offset from the adder and store data comes from p1
	dataMem #(
		.dmemAddrBits(dmemAddrBits)
	) dataMem_inst (
		.clk       (clk),
		.addr      (aluResult[dmemAddrBits-1:0]),
		.writeData (p1Data),
		.memWe     (memWe),
		.memRe     (memRe),
		.readData  (memData)
	);

	// Write-back select with the JAL link first
	assign writeData = jal ? pcPlus1 :
		memToReg ? memData :
		aluResult;

endmodule

`default_nettype wire

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb
	import cpuPkg::*;
();

	localparam int imemAddrBits = 8;
	localparam int dmemAddrBits = 8;
	// Five programs of up to 64 words loaded and run plus reads and margin
	localparam int maxCycles = 2000;

	logic                    clk;
	logic                    arstN;
	logic                    imemWe;
	logic [imemAddrBits-1:0] imemAddr;
	logic [15:0]             imemData;
	logic [3:0]              dbgAddr;
	logic [15:0]             pc;
	logic                    halted;
	logic [15:0]             dbgData;

	int          seed;
	int          errorCount;
	int          checkCount;
	int          cycleCount;
	logic [15:0] prog [$];
	// Expected register contents while constants are built
	logic [15:0] shadow [16];

	cpuCore #(
		.imemAddrBits(imemAddrBits),
		.dmemAddrBits(dmemAddrBits)
	) cpuCore_inst (
		.clk      (clk),
		.arstN    (arstN),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.dbgAddr  (dbgAddr),
		.pc       (pc),
		.halted   (halted),
		.dbgData  (dbgData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Watchdog over the whole run
	initial begin
		cycleCount = 0;
		while (cycleCount < maxCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the program never halted within %0d cycles", maxCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// Instruction encodings
	function automatic logic [15:0] rWord(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] iWord(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] bWord(input logic [2:0] cond, input logic [8:0] off);
		return {opB, cond, off};
	endfunction

	function automatic logic [15:0] jalWord(input logic [11:0] off);
		return {opJal, off};
	endfunction

	// Flags zr, ne and ov left by SUB of x and y
	function automatic logic [2:0] subFlags(input logic [15:0] x, input logic [15:0] y);
		logic [15:0] d;
		d = x - y;
		return {d == 16'h0, d[15], (x[15] != y[15]) && (d[15] != x[15])};
	endfunction

	function automatic logic condHolds(input logic [2:0] cond, input logic [2:0] f);
		case (cond)
			condNe:  return !f[2];
			condEq:  return f[2];
			condGt:  return !f[2] && !f[1];
			condLt:  return f[1];
			condGte: return !f[1];
			condLte: return f[1] || f[2];
			condOvfl: return f[0];
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic addOverflows(input logic [15:0] x, input logic [15:0] y);
		logic [15:0] s;
		s = x + y;
		return (x[15] == y[15]) && (s[15] != x[15]);
	endfunction

	task automatic emit(input logic [15:0] word);
		prog.push_back(word);
	endtask

	task automatic clearProgram();
		prog.delete();
		for (int i = 0; i < 16; i++)
			shadow[i] = 16'h0;
	endtask

	// LLB adds the sign extended byte to the register named by its upper nibble
	task automatic emitConst(input logic [3:0] rd, input logic [15:0] target);
		logic [15:0] low;
		low = shadow[target[7:4]] + {{8{target[7]}}, target[7:0]};
		emit(iWord(opLlb, rd, target[7:0]));
		emit(iWord(opLhb, rd, target[15:8]));
		shadow[rd] = {target[15:8], low[7:0]};
	endtask

	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR %s: actual 0x%04h, expected 0x%04h", name, actual, expected);
		end
	endtask

	task automatic expectReg(input logic [3:0] r, input logic [15:0] expected);
		@(negedge clk);
		dbgAddr = r;
		#5;
		checkValue($sformatf("R%0d", r), dbgData, expected);
	endtask

	// Load under reset then release and wait for halt
	task automatic runProgram();
		@(negedge clk);
		arstN = 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			imemWe = 1'b1;
			imemAddr = 8'(i);
			imemData = prog[i];
			@(negedge clk);
		end
		imemWe = 1'b0;
		// Reset stays low for at least 10 cycles
		for (int i = prog.size(); i < 10; i++)
			@(negedge clk);
		arstN = 1'b1;
		while (!halted)
			@(negedge clk);
	endtask

	task automatic aluOps();
		logic [31:0] rnd;
		logic [3:0]  sh;
		logic [15:0] a;
		logic [15:0] b;
		clearProgram();
		rnd = $random(seed);
		emitConst(4'd1, rnd[15:0]);
		rnd = $random(seed);
		emitConst(4'd2, rnd[15:0]);
		rnd = $random(seed);
		sh = rnd[3:0];
		emit(rWord(opAdd, 4'd3, 4'd1, 4'd2));
		emit(rWord(opSub, 4'd4, 4'd1, 4'd2));
		emit(rWord(opAnd, 4'd5, 4'd1, 4'd2));
		emit(rWord(opNor, 4'd6, 4'd1, 4'd2));
		// Shift amount sits in the rt field
		emit(rWord(opSll, 4'd7, 4'd1, sh));
		emit(rWord(opSrl, 4'd8, 4'd1, sh));
		emit(rWord(opSra, 4'd9, 4'd1, sh));
		emit(rWord(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();
		a = shadow[1];
		b = shadow[2];
		expectReg(4'd1, a);
		expectReg(4'd2, b);
		expectReg(4'd3, a + b);
		expectReg(4'd4, a - b);
		expectReg(4'd5, a & b);
		expectReg(4'd6, ~(a | b));
		expectReg(4'd7, a << sh);
		expectReg(4'd8, a >> sh);
		expectReg(4'd9, $signed(a) >>> sh);
	endtask

	task automatic flagsAndAddz();
		logic [15:0] r1;
		logic [15:0] r2;
		clearProgram();
		emitConst(4'd1, 16'h1205);
		emitConst(4'd2, 16'h0307);
		// Zero result lets the next ADDZ write
		emit(rWord(opSub, 4'd3, 4'd1, 4'd1));
		emit(rWord(opAddz, 4'd4, 4'd1, 4'd2));
		// Non-zero result drops this ADDZ
		emit(rWord(opSub, 4'd5, 4'd1, 4'd2));
		emit(rWord(opAddz, 4'd6, 4'd1, 4'd2));
		emitConst(4'd7, 16'h7fff);
		emitConst(4'd8, 16'h0001);
		emit(rWord(opAdd, 4'd9, 4'd7, 4'd8));
		emit(bWord(condOvfl, 9'd1));
		emit(iWord(opLlb, 4'd10, 8'h01));
		emit(iWord(opLlb, 4'd11, 8'h02));
		emit(rWord(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();
		r1 = shadow[1];
		r2 = shadow[2];
		expectReg(4'd3, 16'h0000);
		expectReg(4'd4, r1 + r2);
		expectReg(4'd5, r1 - r2);
		expectReg(4'd6, ((r1 - r2) == 16'h0) ? r1 + r2 : 16'h0000);
		expectReg(4'd9, shadow[7] + shadow[8]);
		expectReg(4'd10, addOverflows(shadow[7], shadow[8]) ? 16'h0000 : 16'h0001);
		expectReg(4'd11, 16'h0002);
	endtask

	task automatic storeLoad();
		logic [31:0] rnd;
		clearProgram();
		emitConst(4'd1, 16'h0010);
		emitConst(4'd2, 16'h0020);
		for (int r = 3; r <= 5; r++) begin
			rnd = $random(seed);
			emitConst(4'(r), rnd[15:0]);
		end
		// Offsets are the signed rt nibble
		emit(rWord(opSw, 4'd3, 4'd1, 4'd2));
		emit(rWord(opSw, 4'd4, 4'd1, 4'hf));
		emit(rWord(opSw, 4'd5, 4'd2, 4'd7));
		emit(rWord(opLw, 4'd6, 4'd1, 4'd2));
		emit(rWord(opLw, 4'd7, 4'd1, 4'hf));
		emit(rWord(opLw, 4'd8, 4'd2, 4'd7));
		// Overwrite one word and read it again
		emit(rWord(opSw, 4'd5, 4'd1, 4'd2));
		emit(rWord(opLw, 4'd10, 4'd1, 4'd2));
		emit(rWord(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();
		expectReg(4'd6, shadow[3]);
		expectReg(4'd7, shadow[4]);
		expectReg(4'd8, shadow[5]);
		expectReg(4'd10, shadow[5]);
	endtask

	task automatic branchConditions();
		logic [3:0] srcA [4];
		logic [3:0] srcB [4];
		logic [2:0] f;
		int         s;
		int         count [8];
		// Operand pairs giving zero, negative, positive and overflow
		srcA[0] = 4'd1;
		srcB[0] = 4'd1;
		srcA[1] = 4'd1;
		srcB[1] = 4'd2;
		srcA[2] = 4'd2;
		srcB[2] = 4'd1;
		srcA[3] = 4'd3;
		srcB[3] = 4'd12;
		clearProgram();
		emitConst(4'd1, 16'h0005);
		emitConst(4'd2, 16'h0009);
		emitConst(4'd3, 16'h7fff);
		emitConst(4'd12, 16'hffff);
		emitConst(4'd13, 16'h0001);
		for (int c = 0; c < 8; c++) begin
			count[c] = 0;
			// First pass wants the branch taken and the second wants it not taken
			for (int k = 0; k < 2; k++) begin
				s = 0;
				for (int t = 3; t >= 0; t--) begin
					f = subFlags(shadow[srcA[t]], shadow[srcB[t]]);
					if (condHolds(3'(c), f) == (k == 0))
						s = t;
				end
				f = subFlags(shadow[srcA[s]], shadow[srcB[s]]);
				if (!condHolds(3'(c), f))
					count[c]++;
				emit(rWord(opSub, 4'd14, srcA[s], srcB[s]));
				emit(bWord(3'(c), 9'd1));
				emit(rWord(opAdd, 4'(c + 4), 4'(c + 4), 4'd13));
			end
		end
		emit(rWord(opAdd, 4'd0, 4'd1, 4'd2));
		emit(rWord(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();
		for (int c = 0; c < 8; c++)
			expectReg(4'(c + 4), 16'(count[c]));
		expectReg(4'd0, 16'h0000);
	endtask

	task automatic jumpReturnHalt();
		int          jalAddr;
		int          hltAddr;
		logic [15:0] frozenPc;
		clearProgram();
		emit(iWord(opLlb, 4'd1, 8'h03));
		jalAddr = prog.size();
		// Subroutine sits three words past the return point
		emit(jalWord(12'd3));
		emit(rWord(opAdd, 4'd2, 4'd1, 4'd1));
		hltAddr = prog.size();
		emit(rWord(opHlt, 4'd0, 4'd0, 4'd0));
		emit(iWord(opLlb, 4'd3, 8'h07));
		emit(iWord(opLlb, 4'd4, 8'h09));
		emit(rWord(opJr, 4'd0, 4'd15, 4'd0));
		runProgram();
		expectReg(4'd15, 16'(jalAddr + 1));
		expectReg(4'd2, 16'h0006);
		expectReg(4'd3, 16'h0000);
		expectReg(4'd4, 16'h0009);
		@(negedge clk);
		frozenPc = pc;
		checkValue("pc", pc, 16'(hltAddr));
		repeat (20) begin
			@(negedge clk);
			checkValue("pc", pc, frozenPc);
			checkValue("halted", {15'h0, halted}, 16'h0001);
		end
		// Registers frozen too
		expectReg(4'd2, 16'h0006);
	endtask

	initial begin
		seed = 48509;
		errorCount = 0;
		checkCount = 0;
		arstN = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dbgAddr = '0;
		repeat (10) @(negedge clk);
		aluOps();
		flagsAndAddz();
		storeLoad();
		branchConditions();
		jumpReturnHalt();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/cpuPkg.sv
source/instrDecode.sv
source/regFile.sv
source/alu.sv
source/fetchUnit.sv
source/dataMem.sv
source/cpuCore.sv
tests/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f sim.f --top-module cpuTb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VcpuTb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
